// File: src/dz_pkg.sv
package dz_pkg;

    // Matrix geometry.
    localparam int ROWS = 8;
    localparam int ROW_W = 8;   // One-hot row select.
    localparam int COL_W = 8;   // Per colour column bus.

    // Digit and row index share one width.
    localparam int DIGIT_W = 3;

    // Loads above this clamp to it.
    localparam int MAX_DIGIT = 5;

endpackage

// File: src/tick_gen.sv
`timescale 1ns/1ps

module tick_gen #(
    parameter int TICK_DIV = 50_000_000
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == CNT_W'(TICK_DIV - 1));

    // Start realigns the phase so steps follow the user.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (start)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;   // One cycle per wrap.
        end
    end

endmodule

// File: src/dz_ctrl.sv
`timescale 1ns/1ps

module dz_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [dz_pkg::DIGIT_W-1:0] start_val,
    input  logic                       tick,
    output logic [dz_pkg::DIGIT_W-1:0] digit,
    output logic                       show,
    output logic                       busy,
    output logic                       done
);

    logic [dz_pkg::DIGIT_W-1:0] load_val;
    logic                       last_step;

    // Clamp at load.
    always_comb
    begin
        if (start_val > dz_pkg::DIGIT_W'(dz_pkg::MAX_DIGIT))
            load_val = dz_pkg::DIGIT_W'(dz_pkg::MAX_DIGIT);
        else
            load_val = start_val;
    end

    assign last_step = (digit == dz_pkg::DIGIT_W'(1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit <= '0;
            show  <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                // Restart wins over any pending tick.
                digit <= load_val;
                show  <= 1'b1;
                busy  <= (load_val != '0);
                done  <= (load_val == '0);   // Zero load finishes at once.
            end
            else if (busy && tick)
            begin
                digit <= digit - 1'b1;
                if (last_step)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Idle ticks fall through and digit 0 stays lit until the next start.

endmodule

// File: src/row_scan.sv
`timescale 1ns/1ps

module row_scan #(
    parameter int SCAN_DIV = 1000
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic [dz_pkg::DIGIT_W-1:0] row_idx
);

    localparam int PRE_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [PRE_W-1:0] pre;
    logic             step;
    logic             last_row;

    assign step     = (pre == PRE_W'(SCAN_DIV - 1));
    assign last_row = (row_idx == dz_pkg::DIGIT_W'(dz_pkg::ROWS - 1));

    // Prescaler sets how long each row stays lit.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pre <= '0;
        else if (step)
            pre <= '0;
        else
            pre <= pre + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (step)
        begin
            if (last_row)
                row_idx <= '0;
            else
                row_idx <= row_idx + 1'b1;
        end
    end

endmodule

// File: src/dz_show.sv
`timescale 1ns/1ps

module dz_show (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [dz_pkg::DIGIT_W-1:0] digit,
    input  logic                       show,
    input  logic [dz_pkg::DIGIT_W-1:0] row_idx,
    output logic [dz_pkg::ROW_W-1:0]   row,
    output logic [dz_pkg::COL_W-1:0]   colr,
    output logic [dz_pkg::COL_W-1:0]   colg
);

    logic [dz_pkg::COL_W-1:0] glyph;
    logic                     red_on;
    logic                     grn_on;

    // Row 0 of every glyph is the blank top line.
    function automatic logic [dz_pkg::COL_W-1:0] glyph_row(
        input logic [dz_pkg::DIGIT_W-1:0] d,
        input logic [dz_pkg::DIGIT_W-1:0] r
    );
        logic [dz_pkg::COL_W-1:0] bits;
        bits = '0;
        case (d)
            3'd5:
            begin
                case (r)
                    3'd1:       bits = 8'b0111_1110;
                    3'd2:       bits = 8'b0110_0000;
                    3'd3:       bits = 8'b0111_1100;
                    3'd4, 3'd5: bits = 8'b0000_0110;
                    3'd6:       bits = 8'b0110_0110;
                    3'd7:       bits = 8'b0011_1100;
                    default:    bits = '0;
                endcase
            end
            3'd4:
            begin
                case (r)
                    3'd1, 3'd6, 3'd7: bits = 8'b0000_1100;
                    3'd2:             bits = 8'b0001_1100;
                    3'd3:             bits = 8'b0010_1100;
                    3'd4:             bits = 8'b0100_1100;
                    3'd5:             bits = 8'b0111_1110;
                    default:          bits = '0;
                endcase
            end
            3'd3:
            begin
                case (r)
                    3'd1, 3'd7: bits = 8'b0011_1100;
                    3'd2, 3'd6: bits = 8'b0110_0110;
                    3'd3, 3'd5: bits = 8'b0000_0110;
                    3'd4:       bits = 8'b0001_1100;
                    default:    bits = '0;
                endcase
            end
            3'd2:
            begin
                case (r)
                    3'd1:    bits = 8'b0011_1100;
                    3'd2:    bits = 8'b0110_0110;
                    3'd3:    bits = 8'b0000_0110;
                    3'd4:    bits = 8'b0000_1100;
                    3'd5:    bits = 8'b0011_0000;
                    3'd6:    bits = 8'b0110_0000;
                    3'd7:    bits = 8'b0111_1110;
                    default: bits = '0;
                endcase
            end
            3'd1:
            begin
                case (r)
                    3'd1, 3'd2, 3'd4, 3'd5, 3'd6: bits = 8'b0001_1000;
                    3'd3:                         bits = 8'b0011_1000;
                    3'd7:                         bits = 8'b0111_1110;
                    default:                      bits = '0;
                endcase
            end
            3'd0:
            begin
                // Plain ring.
                case (r)
                    3'd1, 3'd7:                   bits = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5, 3'd6: bits = 8'b0100_0010;
                    default:                      bits = '0;
                endcase
            end
            default: bits = '0;   // 6 and 7 never load.
        endcase
        return bits;
    endfunction

    assign glyph = glyph_row(digit, row_idx);

    // Colour runs red to yellow to green as the count runs out.
    assign red_on = (digit >= dz_pkg::DIGIT_W'(2));
    assign grn_on = (digit <= dz_pkg::DIGIT_W'(3));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '0;
            colr <= '0;
            colg <= '0;
        end
        else if (show)
        begin
            row  <= dz_pkg::ROW_W'(1) << row_idx;
            colr <= red_on ? glyph : '0;
            colg <= grn_on ? glyph : '0;
        end
        else
        begin
            // Dark until the first start.
            row  <= '0;
            colr <= '0;
            colg <= '0;
        end
    end

endmodule

// File: src/dz_top.sv
`timescale 1ns/1ps

module dz_top #(
    parameter int TICK_DIV = 50_000_000,   // One second at 50 MHz.
    parameter int SCAN_DIV = 6250          // About 1 kHz frame rate.
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [dz_pkg::DIGIT_W-1:0] start_val,
    output logic [dz_pkg::ROW_W-1:0]   row,
    output logic [dz_pkg::COL_W-1:0]   colr,
    output logic [dz_pkg::COL_W-1:0]   colg,
    output logic                       busy,
    output logic                       done
);

    logic                       tick;
    logic [dz_pkg::DIGIT_W-1:0] digit;
    logic                       show;
    logic [dz_pkg::DIGIT_W-1:0] row_idx;

    tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) u_tick_gen (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .tick  (tick)
    );

    dz_ctrl u_dz_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .start_val (start_val),
        .tick      (tick),
        .digit     (digit),
        .show      (show),
        .busy      (busy),
        .done      (done)
    );

    // Scans freely from reset.
    row_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_row_scan (
        .clk     (clk),
        .rst     (rst),
        .row_idx (row_idx)
    );

    dz_show u_dz_show (
        .clk     (clk),
        .rst     (rst),
        .digit   (digit),
        .show    (show),
        .row_idx (row_idx),
        .row     (row),
        .colr    (colr),
        .colg    (colg)
    );

endmodule

// File: bench/dz_chk.sv
`timescale 1ns/1ps

module dz_chk (
    input logic                     clk,
    input logic                     rst,
    input logic [dz_pkg::ROW_W-1:0] row,
    input logic [dz_pkg::COL_W-1:0] colr,
    input logic [dz_pkg::COL_W-1:0] colg,
    input logic                     busy,
    input logic                     done
);

    a_row_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(row))
        else $error("row drives more than one line");

    // No column may light while all rows are off.
    a_cols_dark: assert property (@(posedge clk) disable iff (rst)
        (row == '0) |-> (colr == '0 && colg == '0))
        else $error("columns lit with row bus dark");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held longer than one cycle");

    a_busy_after_done: assert property (@(posedge clk) disable iff (rst) done |=> !busy)
        else $error("busy high after done");

    // Yellow means the same glyph on both buses.
    a_yellow_match: assert property (@(posedge clk) disable iff (rst)
        (colr != '0 && colg != '0) |-> (colr == colg))
        else $error("red and green buses disagree");

endmodule

bind dz_top dz_chk u_chk (
    .clk  (clk),
    .rst  (rst),
    .row  (row),
    .colr (colr),
    .colg (colg),
    .busy (busy),
    .done (done)
);

// File: bench/dz_tb.sv
`timescale 1ns/1ps

module dz_tb;

    localparam int TICK_DIV = 64;
    localparam int SCAN_DIV = 4;
    localparam int SCAN_LEN = dz_pkg::ROWS * SCAN_DIV;   // One full frame.

    logic                       clk;
    logic                       rst;
    logic                       start;
    logic [dz_pkg::DIGIT_W-1:0] start_val;
    logic [dz_pkg::ROW_W-1:0]   row;
    logic [dz_pkg::COL_W-1:0]   colr;
    logic [dz_pkg::COL_W-1:0]   colg;
    logic                       busy;
    logic                       done;

    int cyc;
    int start_cyc;
    int elapsed;
    int err_cnt;
    int err_mark;
    int tests_run;
    int tests_failed;
    int hold;
    int prev_idx;
    int rnd_val;
    bit seen [dz_pkg::ROWS];

    dz_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .start_val (start_val),
        .row       (row),
        .colr      (colr),
        .colg      (colg),
        .busy      (busy),
        .done      (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;   // Read only on falling edges.

    // Byte r holds glyph row r and row 0 is blank.
    function automatic logic [63:0] glyph_word(int d);
        case (d)
            5:       return 64'h3C66_0606_7C60_7E00;
            4:       return 64'h0C0C_7E4C_2C1C_0C00;
            3:       return 64'h3C66_061C_0666_3C00;
            2:       return 64'h7E60_300C_0666_3C00;
            1:       return 64'h7E18_1818_3818_1800;
            0:       return 64'h3C42_4242_4242_3C00;
            default: return 64'h0;
        endcase
    endfunction

    function automatic logic [dz_pkg::COL_W-1:0] glyph_bits(int d, int r);
        logic [63:0] w;
        w = glyph_word(d);
        return w[r*8 +: 8];
    endfunction

    function automatic bit red_lit(int d);
        return (d == 5) || (d == 4) || (d == 3) || (d == 2);
    endfunction

    function automatic bit green_lit(int d);
        return (d == 3) || (d == 2) || (d == 1) || (d == 0);
    endfunction

    function automatic int row_index(logic [dz_pkg::ROW_W-1:0] r);
        for (int i = 0; i < dz_pkg::ROW_W; i++)
            if (r[i])
                return i;
        return -1;
    endfunction

    task automatic check_bus(string name, logic [dz_pkg::COL_W-1:0] got,
                             logic [dz_pkg::COL_W-1:0] exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            err_cnt++;
            $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp)
        begin
            err_cnt++;
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_dark();
        check_bus("row", row, '0);
        check_bus("colr", colr, '0);
        check_bus("colg", colg, '0);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
    endtask

    // One display cycle against digit d.
    task automatic check_frame(int d);
        int                       idx;
        logic [dz_pkg::COL_W-1:0] g;
        idx = row_index(row);
        if (idx < 0)
        begin
            err_cnt++;
            $display("Row bus dark at %0t while digit %0d should show", $time, d);
        end
        else
        begin
            g = glyph_bits(d, idx);
            check_bus("row", row, dz_pkg::ROW_W'(1) << idx);
            check_bus("colr", colr, red_lit(d) ? g : '0);
            check_bus("colg", colg, green_lit(d) ? g : '0);
            seen[idx] = 1'b1;
        end
    endtask

    function automatic int rows_seen();
        int n;
        n = 0;
        foreach (seen[i])
            if (seen[i])
                n++;
        return n;
    endfunction

    // Watch until every row has shown digit d.
    task automatic scan_rows(int d);
        int n;
        n = 0;
        foreach (seen[i])
            seen[i] = 1'b0;
        while (rows_seen() < dz_pkg::ROWS && n < 2 * SCAN_LEN)
        begin
            @(negedge clk);
            check_frame(d);
            n++;
        end
        if (rows_seen() < dz_pkg::ROWS)
        begin
            err_cnt++;
            $display("Timeout: not every row of digit %0d was scanned", d);
        end
    endtask

    task automatic hold_check(int n, int d);
        foreach (seen[i])
            seen[i] = 1'b0;
        repeat (n)
        begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
            check_frame(d);
        end
        if (rows_seen() < dz_pkg::ROWS)
        begin
            err_cnt++;
            $display("Held digit %0d did not cover every row", d);
        end
    endtask

    task automatic pulse_start(int v);
        start     = 1'b1;
        start_val = dz_pkg::DIGIT_W'(v);
        @(negedge clk);
        start     = 1'b0;
        start_cyc = cyc;   // Edges counted from the start edge.
    endtask

    task automatic wait_until(int k, logic exp_busy);
        int guard;
        guard = 0;
        while (cyc - start_cyc < k && guard < k + 8)
        begin
            @(negedge clk);
            check_flag("busy", busy, exp_busy);
            check_flag("done", done, 1'b0);
            guard++;
        end
        if (cyc - start_cyc < k)
        begin
            err_cnt++;
            $display("Timeout waiting for cycle %0d after start", k);
        end
    endtask

    task automatic wait_done(int limit);
        int n;
        n = 0;
        while (done !== 1'b1 && n < limit)
        begin
            check_flag("busy", busy, 1'b1);
            @(negedge clk);
            n++;
        end
        elapsed = cyc - start_cyc;
        if (done === 1'b1)
            check_flag("busy", busy, 1'b0);
        else
        begin
            err_cnt++;
            $display("Timeout after %0d cycles waiting for done", limit);
        end
    endtask

    // Each digit is scanned well clear of its step edges.
    task automatic run_countdown(int v);
        int n;
        n = (v > dz_pkg::MAX_DIGIT) ? dz_pkg::MAX_DIGIT : v;
        pulse_start(v);
        for (int j = 0; j < n; j++)
        begin
            wait_until(j * TICK_DIV + 4, 1'b1);
            scan_rows(n - j);
        end
        wait_done((n + 1) * TICK_DIV);
        check_count("done latency", elapsed, n * TICK_DIV + 1);
        hold_check(SCAN_LEN + SCAN_DIV, 0);
    endtask

    task automatic wait_row_change(output int n);
        logic [dz_pkg::ROW_W-1:0] prev;
        prev = row;
        n    = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (row === prev && n < 4 * SCAN_DIV);
        if (row === prev)
        begin
            err_cnt++;
            $display("Timeout: row bus stopped stepping");
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (err_cnt == err_mark)
            $display("Test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("Test %s: %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    initial
    begin
        rst       = 1'b1;
        start     = 1'b0;
        start_val = '0;
        void'($urandom(86112));

        repeat (5)
        begin
            @(negedge clk);
            check_dark();
        end
        rst = 1'b0;
        repeat (SCAN_LEN)
        begin
            @(negedge clk);
            check_dark();
        end
        end_test("reset");

        run_countdown(5);
        end_test("countdown from 5");

        wait_row_change(hold);   // Align to a row boundary.
        for (int i = 0; i < dz_pkg::ROWS + 2; i++)
        begin
            prev_idx = row_index(row);
            wait_row_change(hold);
            check_bus("row", row, dz_pkg::ROW_W'(1) << ((prev_idx + 1) % dz_pkg::ROWS));
            check_count("row hold cycles", hold, SCAN_DIV);
        end
        end_test("scan order");

        run_countdown(6);
        run_countdown(7);
        pulse_start(3);
        wait_until(4, 1'b1);   // A running count makes the zero load visible.
        pulse_start(0);
        wait_done(2);
        check_count("zero load done latency", elapsed, 0);   // Done on the load edge.
        hold_check(SCAN_LEN + SCAN_DIV, 0);
        end_test("clamp and zero load");

        rnd_val = 1 + int'($urandom % 5);
        pulse_start(5);
        wait_until(2 * TICK_DIV + 10, 1'b1);
        pulse_start(rnd_val);
        wait_until(4, 1'b1);
        scan_rows(rnd_val);
        wait_done((rnd_val + 1) * TICK_DIV);
        check_count("restart done latency", elapsed, rnd_val * TICK_DIV + 1);
        hold_check(2 * TICK_DIV, 0);   // A second done would show here.
        end_test("restart");

        run_countdown(1);
        hold_check(4 * TICK_DIV, 0);
        end_test("hold after done");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: list.f
src/dz_pkg.sv
src/tick_gen.sv
src/dz_ctrl.sv
src/row_scan.sv
src/dz_show.sv
src/dz_top.sv
bench/dz_chk.sv
bench/dz_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dz_tb
RTL_TOP   ?= dz_top
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= src/dz_pkg.sv src/tick_gen.sv src/dz_ctrl.sv src/row_scan.sv \
             src/dz_show.sv src/dz_top.sv
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
